// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_isp_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

# the simulator exits non-zero when the testbench stops with $fatal.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
src/video_pkg.sv
src/cfg_pkg.sv
src/line_buffer.sv
src/bayer_demosaic.sv
src/wb_gain.sv
src/cfg_regs.sv
src/isp_top.sv
test/tb_isp_top.sv

// File: src/bayer_demosaic.sv
`timescale 1ns/1ps

module bayer_demosaic import video_pkg::*;
(
	input  logic     i_pclk,
	input  logic     i_arstn,
	input  vtiming_t i_timing,
	input  win_t     i_win,
	input  pos_t     i_pos,
	output vtiming_t o_timing,
	output rgb_t     o_rgb
);

	pix_t           w_r;
	pix_t           w_b;
	pix_t           w_g0;
	pix_t           w_g1;
	logic [PIX_W:0] w_g_sum;	// one extra bit so the average does not wrap.

	vtiming_t       r_timing;
	rgb_t           r_rgb;

	// ------------------------------
	// RGGB site selection
	// ------------------------------
	// cur sits at (x, y), so its parity tells where red and blue fall in the window.
	always_comb
	begin
		case ({i_pos.y[0], i_pos.x[0]})
			2'b00:
			begin
				w_r  = i_win.cur;
				w_b  = i_win.up_left;
				w_g0 = i_win.up;
				w_g1 = i_win.left;
			end
			2'b01:
			begin
				w_r  = i_win.left;	// green on a red row.
				w_b  = i_win.up;
				w_g0 = i_win.cur;
				w_g1 = i_win.up_left;
			end
			2'b10:
			begin
				w_r  = i_win.up;	// green on a blue row.
				w_b  = i_win.left;
				w_g0 = i_win.cur;
				w_g1 = i_win.up_left;
			end
			default:
			begin
				w_r  = i_win.up_left;
				w_b  = i_win.cur;
				w_g0 = i_win.up;
				w_g1 = i_win.left;
			end
		endcase
	end

	assign w_g_sum = {1'b0, w_g0} + {1'b0, w_g1};

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
			r_timing <= '0;
		else
			r_timing <= i_timing;
	end

	always_ff @(posedge i_pclk)
	begin
		r_rgb <= '{r: w_r, g: w_g_sum[PIX_W:1], b: w_b};
	end

	assign o_timing = r_timing;
	assign o_rgb    = r_rgb;

endmodule

// File: src/cfg_pkg.sv
package cfg_pkg;

	// gains are Q2.6, so 64 is a gain of one.
	typedef logic [7:0] gain_t;
	typedef logic [1:0] cfg_addr_t;

	// ------------------------------
	// register map
	// ------------------------------
	localparam cfg_addr_t REG_GAIN_R = 2'd0;
	localparam cfg_addr_t REG_GAIN_G = 2'd1;
	localparam cfg_addr_t REG_GAIN_B = 2'd2;

	localparam gain_t GAIN_UNITY = 8'd64;

	typedef struct packed {
		gain_t r;
		gain_t g;
		gain_t b;
	} gains_t;

endpackage

// File: src/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs import cfg_pkg::*;
(
	input  logic      i_pclk,
	input  logic      i_arstn,
	input  logic      i_vsync,
	input  logic      i_req,
	input  logic      i_we,
	input  cfg_addr_t i_addr,
	input  gain_t     i_wdata,
	output logic      o_ack,
	output gain_t     o_rdata,
	output gains_t    o_gains
);

	typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} state_t;

	state_t r_state;
	gains_t r_pending;	// written by the port, visible to reads.
	gains_t r_shadow;	// what the pipeline uses for the whole frame.
	gain_t  r_rdata;
	logic   r_vs_d;

	// ------------------------------
	// four-phase register port
	// ------------------------------
	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_state   <= IDLE;
			r_pending <= '{r: GAIN_UNITY, g: GAIN_UNITY, b: GAIN_UNITY};
			r_rdata   <= '0;
		end
		else
		begin
			case (r_state)
				IDLE:
				begin
					if (i_req)
					begin
						r_state <= ACK;	// access happens once, on entry.
						if (i_we)
						begin
							case (i_addr)
								REG_GAIN_R: r_pending.r <= i_wdata;
								REG_GAIN_G: r_pending.g <= i_wdata;
								REG_GAIN_B: r_pending.b <= i_wdata;
								default: ;
							endcase
						end
						else
						begin
							case (i_addr)
								REG_GAIN_R: r_rdata <= r_pending.r;
								REG_GAIN_G: r_rdata <= r_pending.g;
								REG_GAIN_B: r_rdata <= r_pending.b;
								default:    r_rdata <= '0;
							endcase
						end
					end
				end
				ACK:
				begin
					if (!i_req)
						r_state <= WAIT_LOW;
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	// pending gains move to the shadow set on the vsync rising edge.
	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_vs_d   <= 1'b0;
			r_shadow <= '{r: GAIN_UNITY, g: GAIN_UNITY, b: GAIN_UNITY};
		end
		else
		begin
			r_vs_d <= i_vsync;
			if (i_vsync && !r_vs_d)
				r_shadow <= r_pending;
		end
	end

	assign o_ack   = (r_state == ACK);
	assign o_rdata = r_rdata;
	assign o_gains = r_shadow;

endmodule

// File: src/isp_top.sv
`timescale 1ns/1ps

module isp_top import video_pkg::*, cfg_pkg::*;
(
	input  logic      i_pclk,
	input  logic      i_arstn,
	input  vtiming_t  i_timing,
	input  pix_t      i_p,
	input  logic      i_req,
	input  logic      i_we,
	input  cfg_addr_t i_addr,
	input  gain_t     i_wdata,
	output vtiming_t  o_timing,
	output rgb_t      o_rgb,
	output logic      o_ack,
	output gain_t     o_rdata
);

	vtiming_t w_lb_timing;
	win_t     w_lb_win;
	pos_t     w_lb_pos;
	vtiming_t w_dm_timing;
	rgb_t     w_dm_rgb;
	gains_t   w_gains;

	// ------------------------------
	// pixel pipeline
	// ------------------------------
	line_buffer u_line_buffer (
		.i_pclk   (i_pclk),
		.i_arstn  (i_arstn),
		.i_timing (i_timing),
		.i_p      (i_p),
		.o_timing (w_lb_timing),
		.o_win    (w_lb_win),
		.o_pos    (w_lb_pos)
	);

	bayer_demosaic u_bayer_demosaic (
		.i_pclk   (i_pclk),
		.i_arstn  (i_arstn),
		.i_timing (w_lb_timing),
		.i_win    (w_lb_win),
		.i_pos    (w_lb_pos),
		.o_timing (w_dm_timing),
		.o_rgb    (w_dm_rgb)
	);

	wb_gain u_wb_gain (
		.i_pclk   (i_pclk),
		.i_arstn  (i_arstn),
		.i_timing (w_dm_timing),
		.i_rgb    (w_dm_rgb),
		.i_gains  (w_gains),
		.o_timing (o_timing),
		.o_rgb    (o_rgb)
	);

	// the shadow load follows the raw input vsync.
	cfg_regs u_cfg_regs (
		.i_pclk  (i_pclk),
		.i_arstn (i_arstn),
		.i_vsync (i_timing.vsync),
		.i_req   (i_req),
		.i_we    (i_we),
		.i_addr  (i_addr),
		.i_wdata (i_wdata),
		.o_ack   (o_ack),
		.o_rdata (o_rdata),
		.o_gains (w_gains)
	);

endmodule

// File: src/line_buffer.sv
`timescale 1ns/1ps

module line_buffer import video_pkg::*;
(
	input  logic     i_pclk,
	input  logic     i_arstn,
	input  vtiming_t i_timing,
	input  pix_t     i_p,
	output vtiming_t o_timing,
	output win_t     o_win,
	output pos_t     o_pos
);

	pix_t     r_mem [0:1][0:MAX_LINE-1];	// one bank per line.
	logic     r_bank;	// bank being written, the other one holds the line above.
	xcnt_t    r_x;
	ycnt_t    r_y;

	vtiming_t r_timing_1p;
	pix_t     r_p_1p;
	pix_t     r_up_1p;
	pos_t     r_pos_1p;

	vtiming_t r_timing_2p;
	win_t     r_win_2p;
	pos_t     r_pos_2p;

	logic     w_vs_rise;
	logic     w_de_fall;

	assign w_vs_rise = i_timing.vsync && !r_timing_1p.vsync;
	assign w_de_fall = !i_timing.de && r_timing_1p.de;

	// ------------------------------
	// column, row and bank tracking
	// ------------------------------
	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_bank <= 1'b0;
			r_x    <= '0;
			r_y    <= '0;
		end
		else if (w_vs_rise)
		begin
			r_bank <= 1'b0;	// every frame starts on bank 0.
			r_x    <= '0;
			r_y    <= '0;
		end
		else
		begin
			if (i_timing.de)
				r_x <= r_x + 1'b1;
			else
				r_x <= '0;
			if (w_de_fall)
			begin
				r_y    <= r_y + 1'b1;
				r_bank <= ~r_bank;
			end
		end
	end

	// write the current line while reading the previous one at the same column.
	always_ff @(posedge i_pclk)
	begin
		if (i_timing.de)
			r_mem[r_bank][r_x] <= i_p;
		r_up_1p <= r_mem[~r_bank][r_x];
	end

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_timing_1p <= '0;
			r_timing_2p <= '0;
		end
		else
		begin
			r_timing_1p <= i_timing;
			r_timing_2p <= r_timing_1p;
		end
	end

	// ------------------------------
	// window assembly with edge masking
	// ------------------------------
	always_ff @(posedge i_pclk)
	begin
		r_p_1p           <= i_p;
		r_pos_1p         <= '{x: r_x, y: r_y};
		r_pos_2p         <= r_pos_1p;
		r_win_2p.cur     <= r_p_1p;
		r_win_2p.up      <= (r_pos_1p.y == '0) ? '0 : r_up_1p;
		r_win_2p.left    <= (r_pos_1p.x == '0) ? '0 : r_win_2p.cur;
		r_win_2p.up_left <= (r_pos_1p.x == '0) ? '0 : r_win_2p.up;	// up is already zero on row 0.
	end

	assign o_timing = r_timing_2p;
	assign o_win    = r_win_2p;
	assign o_pos    = r_pos_2p;

endmodule

// File: src/video_pkg.sv
package video_pkg;

	// ------------------------------
	// frame geometry and latency
	// ------------------------------
	localparam int PIX_W    = 10;
	localparam int MAX_LINE = 2048;	// deepest line the buffer can hold.
	localparam int X_W      = 11;
	localparam int Y_W      = 11;
	localparam int PIPE_LAT = 4;	// line buffer 2, demosaic 1, gain 1.

	// ------------------------------
	// sample and counter types
	// ------------------------------
	typedef logic [PIX_W-1:0] pix_t;
	typedef logic [X_W-1:0]   xcnt_t;
	typedef logic [Y_W-1:0]   ycnt_t;

	// all syncs are active high.
	typedef struct packed {
		logic vsync;
		logic hsync;
		logic de;
	} vtiming_t;

	typedef struct packed {
		xcnt_t x;
		ycnt_t y;
	} pos_t;

	// cur is the pixel at pos, the others are its neighbours above and to the left.
	typedef struct packed {
		pix_t up_left;
		pix_t up;
		pix_t left;
		pix_t cur;
	} win_t;

	typedef struct packed {
		pix_t r;
		pix_t g;
		pix_t b;
	} rgb_t;

endpackage

// File: src/wb_gain.sv
`timescale 1ns/1ps

module wb_gain import video_pkg::*, cfg_pkg::*;
(
	input  logic     i_pclk,
	input  logic     i_arstn,
	input  vtiming_t i_timing,
	input  rgb_t     i_rgb,
	input  gains_t   i_gains,
	output vtiming_t o_timing,
	output rgb_t     o_rgb
);

	vtiming_t r_timing;
	rgb_t     r_rgb;

	// multiply by a Q2.6 gain, round to nearest and clamp to full scale.
	function automatic pix_t apply_gain(input pix_t s, input gain_t g);
		logic [PIX_W+$bits(gain_t)-1:0] prod;
		logic [PIX_W+$bits(gain_t)-1:0] scaled;
		begin
			prod   = s * g;
			prod   = prod + (GAIN_UNITY >> 1);
			scaled = prod >> $clog2(GAIN_UNITY);
			if (scaled > {PIX_W{1'b1}})
				return '1;
			return scaled[PIX_W-1:0];
		end
	endfunction

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
			r_timing <= '0;
		else
			r_timing <= i_timing;
	end

	always_ff @(posedge i_pclk)
	begin
		r_rgb.r <= apply_gain(i_rgb.r, i_gains.r);
		r_rgb.g <= apply_gain(i_rgb.g, i_gains.g);
		r_rgb.b <= apply_gain(i_rgb.b, i_gains.b);
	end

	assign o_timing = r_timing;
	assign o_rgb    = r_rgb;

endmodule

// File: test/tb_isp_top.sv
`timescale 1ns/1ps

module tb_isp_top import video_pkg::*, cfg_pkg::*;
;

	localparam int COLS        = 8;
	localparam int ROWS        = 4;
	localparam int BLANK       = 4;	// blanking cycles between lines.
	localparam int VS_CYC      = 2;
	localparam int RST_CYC     = 4;
	localparam int ACK_WAIT    = 4;
	localparam int FRAME_CYC   = VS_CYC + BLANK + ROWS * (BLANK + COLS) + BLANK;
	localparam int ACCESS_CYC  = 8;
	localparam int TIMEOUT_CYC = RST_CYC + 5 * FRAME_CYC + 20 * ACCESS_CYC + 100;

	localparam vtiming_t T_IDLE = 3'b000;
	localparam vtiming_t T_VS   = 3'b100;
	localparam vtiming_t T_HS   = 3'b010;
	localparam vtiming_t T_DE   = 3'b001;

	typedef struct packed {
		vtiming_t t;
		rgb_t     rgb;
	} exp_t;

	logic      pclk = 1'b0;
	logic      arstn;
	vtiming_t  in_timing;
	pix_t      in_p;
	logic      req;
	logic      we;
	cfg_addr_t addr;
	gain_t     wdata;
	vtiming_t  out_timing;
	rgb_t      out_rgb;
	logic      ack;
	gain_t     rdata;

	rgb_t      exp_rgb;	// model output for the pixel now on the inputs.
	exp_t      exp_q[$];
	exp_t      mon_e;
	logic      mon_en = 1'b0;
	gains_t    pend_gains;
	pix_t      pix_mem [0:ROWS-1][0:COLS-1];
	integer    seed = 14740;
	int        cyc_cnt = 0;
	string     test_name = "startup";

	isp_top dut0 (
		.i_pclk   (pclk),
		.i_arstn  (arstn),
		.i_timing (in_timing),
		.i_p      (in_p),
		.i_req    (req),
		.i_we     (we),
		.i_addr   (addr),
		.i_wdata  (wdata),
		.o_timing (out_timing),
		.o_rgb    (out_rgb),
		.o_ack    (ack),
		.o_rdata  (rdata)
	);

	always #5 pclk = ~pclk;

	task finish_run(input bit ok);
		if (ok)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("sim failed");
			$fatal(1);
		end
	endtask

	always @(posedge pclk)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC)
		begin
			$display("timeout: the run went past %0d cycles in %s", TIMEOUT_CYC, test_name);
			finish_run(1'b0);
		end
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task check_rgb(input rgb_t exp, input rgb_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: expected rgb %0d/%0d/%0d, actual %0d/%0d/%0d", test_name,
				exp.r, exp.g, exp.b, act.r, act.g, act.b);
			finish_run(1'b0);
		end
	endtask

	task check_timing(input vtiming_t exp, input vtiming_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: expected timing %b, actual %b", test_name, exp, act);
			finish_run(1'b0);
		end
	endtask

	task check_gain(input gain_t exp, input gain_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: expected gain %0d, actual %0d", test_name, exp, act);
			finish_run(1'b0);
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic pix_t sample_at(input int x, input int y);
		if (x < 0 || y < 0)
			return '0;	// outside the frame reads as black.
		return pix_mem[y][x];
	endfunction

	// the window covers (x, y) and its neighbours up and left, RGGB with red at (0, 0).
	function automatic rgb_t demosaic_model(input int x, input int y);
		int             sx;
		int             sy;
		pix_t           v;
		rgb_t           res;
		logic [PIX_W:0] gsum;
		res  = '0;
		gsum = '0;
		for (int dy = 0; dy < 2; dy++)
		begin
			for (int dx = 0; dx < 2; dx++)
			begin
				sx = x - dx;
				sy = y - dy;
				v  = sample_at(sx, sy);
				if ((sx & 1) == 0 && (sy & 1) == 0)
					res.r = v;
				else if ((sx & 1) == 1 && (sy & 1) == 1)
					res.b = v;
				else
					gsum = gsum + {1'b0, v};
			end
		end
		res.g = gsum[PIX_W:1];
		return res;
	endfunction

	function automatic pix_t gain_model(input pix_t s, input gain_t g);
		int v;
		v = (int'(s) * int'(g) + 32) >>> 6;
		if (v > 1023)
			v = 1023;
		return pix_t'(v);
	endfunction

	function automatic rgb_t expected_out(input int x, input int y, input gains_t g);
		rgb_t c;
		c = demosaic_model(x, y);
		return '{r: gain_model(c.r, g.r), g: gain_model(c.g, g.g), b: gain_model(c.b, g.b)};
	endfunction

	// outputs settle after the edge, so they are compared on the falling edge.
	always @(negedge pclk)
	begin
		if (mon_en)
		begin
			exp_q.push_back('{t: in_timing, rgb: exp_rgb});
			if (exp_q.size() > PIPE_LAT)
			begin
				mon_e = exp_q.pop_front();
				check_timing(mon_e.t, out_timing);
				if (mon_e.t.de)
					check_rgb(mon_e.rgb, out_rgb);
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	task drive_cycle(input vtiming_t t, input pix_t p, input rgb_t e);
		@(posedge pclk);
		in_timing <= t;
		in_p      <= p;
		exp_rgb   <= e;
	endtask

	// kind 0 is a ramp, 1 is random and anything else a flat field of 1000.
	task automatic drive_frame(input int kind);
		gains_t fg;
		for (int y = 0; y < ROWS; y++)
		begin
			for (int x = 0; x < COLS; x++)
			begin
				case (kind)
					0:       pix_mem[y][x] = pix_t'(y * 37 + x * 113);
					1:       pix_mem[y][x] = pix_t'($random(seed));
					default: pix_mem[y][x] = pix_t'(1000);
				endcase
			end
		end
		fg = pend_gains;	// the DUT takes this set on the coming vsync.
		repeat (VS_CYC) drive_cycle(T_VS, '0, '0);
		repeat (BLANK) drive_cycle(T_IDLE, '0, '0);
		for (int y = 0; y < ROWS; y++)
		begin
			drive_cycle(T_HS, '0, '0);
			repeat (BLANK - 1) drive_cycle(T_IDLE, '0, '0);
			for (int x = 0; x < COLS; x++)
				drive_cycle(T_DE, pix_mem[y][x], expected_out(x, y, fg));
		end
		repeat (BLANK) drive_cycle(T_IDLE, '0, '0);
	endtask

	task automatic reg_access(input logic w, input cfg_addr_t a, input gain_t d,
		output gain_t rd);
		int n;
		@(posedge pclk);
		req   <= 1'b1;
		we    <= w;
		addr  <= a;
		wdata <= d;
		n = 0;
		do
		begin
			@(negedge pclk);
			n++;
		end
		while (!ack && n < ACK_WAIT);
		if (!ack)
		begin
			$display("%s: access to address %0d was never acknowledged", test_name, a);
			finish_run(1'b0);
		end
		rd = rdata;
		@(posedge pclk);
		req <= 1'b0;
		n = 0;
		do
		begin
			@(negedge pclk);
			n++;
		end
		while (ack && n < ACK_WAIT);
		if (ack)
		begin
			$display("%s: ack stayed high after req was dropped", test_name);
			finish_run(1'b0);
		end
	endtask

	task automatic reg_write(input cfg_addr_t a, input gain_t d);
		gain_t unused;
		reg_access(1'b1, a, d, unused);
		case (a)
			REG_GAIN_R: pend_gains.r = d;
			REG_GAIN_G: pend_gains.g = d;
			REG_GAIN_B: pend_gains.b = d;
			default: ;
		endcase
	endtask

	task automatic read_expect(input cfg_addr_t a, input gain_t exp);
		gain_t rd;
		reg_access(1'b0, a, '0, rd);
		check_gain(exp, rd);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task reset_idle();
		test_name = "reset_idle";
		@(negedge pclk);
		check_timing(T_IDLE, out_timing);
		check_gain('0, rdata);
		if (ack !== 1'b0)
		begin
			$display("FAIL %s: expected ack 0, actual %b", test_name, ack);
			finish_run(1'b0);
		end
		read_expect(REG_GAIN_R, GAIN_UNITY);
		read_expect(REG_GAIN_G, GAIN_UNITY);
		read_expect(REG_GAIN_B, GAIN_UNITY);
	endtask

	task timing_alignment();
		test_name = "timing_alignment";
		drive_frame(0);
	endtask

	task random_demosaic();
		test_name = "random_demosaic";
		drive_frame(1);
	endtask

	task register_access();
		test_name = "register_access";
		reg_write(REG_GAIN_R, 8'd80);
		reg_write(REG_GAIN_G, 8'd72);
		reg_write(REG_GAIN_B, 8'd56);
		read_expect(REG_GAIN_R, 8'd80);
		read_expect(REG_GAIN_G, 8'd72);
		read_expect(REG_GAIN_B, 8'd56);
		reg_write(2'd3, 8'h5a);	// unknown address, must be ignored.
		read_expect(2'd3, '0);
	endtask

	task frame_gain_update();
		test_name = "frame_gain_update";
		fork
			drive_frame(0);
			begin
				repeat (20) @(posedge pclk);
				reg_write(REG_GAIN_R, 8'd96);
				reg_write(REG_GAIN_G, 8'd48);
				reg_write(REG_GAIN_B, 8'd128);
			end
		join
		drive_frame(0);
	endtask

	task saturation();
		test_name = "saturation";
		reg_write(REG_GAIN_R, 8'd255);
		reg_write(REG_GAIN_G, 8'd255);
		reg_write(REG_GAIN_B, 8'd255);
		drive_frame(2);
	endtask

	initial
	begin
		arstn      = 1'b0;
		in_timing  = T_IDLE;
		in_p       = '0;
		req        = 1'b0;
		we         = 1'b0;
		addr       = '0;
		wdata      = '0;
		exp_rgb    = '0;
		pend_gains = '{r: GAIN_UNITY, g: GAIN_UNITY, b: GAIN_UNITY};
		repeat (RST_CYC) @(posedge pclk);
		arstn <= 1'b1;
		mon_en = 1'b1;
		reset_idle();
		timing_alignment();
		random_demosaic();
		register_access();
		frame_gain_update();
		saturation();
		repeat (PIPE_LAT + 2) drive_cycle(T_IDLE, '0, '0);
		@(negedge pclk);
		finish_run(1'b1);
	end

endmodule
